// ==== Makefile ====
# Verilator flow for the DTW engine testbench
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_dtw_accel
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TEST RESULT: PASS
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
hdl/dtw_pkg.sv
hdl/csr_pkg.sv
hdl/dtw_csr.sv
hdl/dtw_feeder.sv
hdl/dtw_pe.sv
hdl/dtw_drain.sv
hdl/dtw_accel.sv
testbench/dtw_accel_properties.sv
testbench/tb_dtw_accel.sv

// ==== hdl/csr_pkg.sv ====
/*
 * Register map of the DTW engine
 * Word indices, control and status layouts, identity constants
 */
`default_nettype none

package csr_pkg;

    localparam int ADDR_W = 16;

    typedef logic [ADDR_W-3:0] reg_idx_t;

    localparam reg_idx_t REG_CONTROL     = 14'd0;
    localparam reg_idx_t REG_STATUS      = 14'd1;
    localparam reg_idx_t REG_VERSION     = 14'd3;
    localparam reg_idx_t REG_KEY         = 14'd4;
    localparam reg_idx_t REG_QUERY_COUNT = 14'd5;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        mode;
        logic        run;
        logic        soft_reset;
    } ctrl_t;

    typedef struct packed {
        logic [24:0] rsvd_hi;
        logic        result_pending;
        logic [3:0]  rsvd_mid;
        logic        load_done;
        logic        rsvd_lo;
    } status_t;

    // Major in [31:28], minor in [27:20], revision in [19:16]
    localparam logic [3:0] VERSION_MAJOR    = 4'd1;
    localparam logic [7:0] VERSION_MINOR    = 8'd0;
    localparam logic [3:0] VERSION_REVISION = 4'd0;
    localparam logic [31:0] VERSION_WORD =
        {VERSION_MAJOR, VERSION_MINOR, VERSION_REVISION, 16'h0000};

    localparam logic [31:0] KEY_WORD = 32'h0ca7_cafe;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== hdl/dtw_accel.sv ====
/*
 * DTW distance engine top level
 * AXI4-Lite control, AXI4-Stream samples in and scores out,
 * with a linear systolic array of N_PE elements
 */
`timescale 1ns/1ps
`default_nettype none

module dtw_accel #(
    parameter int N_PE = 8
) (
    input  logic        S_AXI_clk,
    input  logic        w_axi_rst,

    input  logic        i_awvalid,
    input  logic [15:0] i_awaddr,
    output logic        o_awready,
    input  logic        i_wvalid,
    input  logic [31:0] i_wdata,
    output logic        o_wready,
    output logic        o_bvalid,
    input  logic        i_bready,
    output logic [1:0]  o_bresp,
    input  logic        i_arvalid,
    input  logic [15:0] i_araddr,
    output logic        o_arready,
    output logic        o_rvalid,
    input  logic        i_rready,
    output logic [1:0]  o_rresp,
    output logic [31:0] o_rdata,

    input  logic        i_src_tvalid,
    output logic        o_src_tready,
    input  logic [31:0] i_src_tdata,
    input  logic        i_src_tlast,

    output logic        o_sink_tvalid,
    input  logic        i_sink_tready,
    output logic [31:0] o_sink_tdata,
    output logic        o_sink_tlast,
    output logic [3:0]  o_sink_tdest,
    output logic [7:0]  o_sink_tid,
    output logic [3:0]  o_sink_tkeep
);
    import dtw_pkg::*;
    import csr_pkg::*;

    ctrl_t       w_ctrl;
    logic        w_load_done;
    logic        w_result_pending;
    logic [31:0] w_query_count;
    logic        w_advance;
    dtw_link_t   w_link [N_PE+1];

    // One score per packet on a fixed destination
    assign o_sink_tlast = 1'b1;
    assign o_sink_tdest = 4'd1;
    assign o_sink_tid   = '0;
    assign o_sink_tkeep = '1;

    dtw_csr u_csr (
        .S_AXI_clk        (S_AXI_clk),
        .w_axi_rst        (w_axi_rst),
        .i_awvalid        (i_awvalid),
        .i_awaddr         (i_awaddr),
        .o_awready        (o_awready),
        .i_wvalid         (i_wvalid),
        .i_wdata          (i_wdata),
        .o_wready         (o_wready),
        .o_bvalid         (o_bvalid),
        .i_bready         (i_bready),
        .o_bresp          (o_bresp),
        .i_arvalid        (i_arvalid),
        .i_araddr         (i_araddr),
        .o_arready        (o_arready),
        .o_rvalid         (o_rvalid),
        .i_rready         (i_rready),
        .o_rresp          (o_rresp),
        .o_rdata          (o_rdata),
        .o_ctrl           (w_ctrl),
        .i_load_done      (w_load_done),
        .i_result_pending (w_result_pending),
        .i_query_count    (w_query_count)
    );

    dtw_feeder #(
        .N_PE (N_PE)
    ) u_feeder (
        .S_AXI_clk    (S_AXI_clk),
        .w_axi_rst    (w_axi_rst),
        .i_ctrl       (w_ctrl),
        .i_advance    (w_advance),
        .i_src_tvalid (i_src_tvalid),
        .o_src_tready (o_src_tready),
        .i_src_tdata  (i_src_tdata),
        .i_src_tlast  (i_src_tlast),
        .o_link       (w_link[0]),
        .o_load_done  (w_load_done)
    );

    // Element k computes column k+1
    for (genvar k = 0; k < N_PE; k++) begin : g_pe
        dtw_pe u_pe (
            .S_AXI_clk    (S_AXI_clk),
            .w_axi_rst    (w_axi_rst),
            .i_soft_reset (w_ctrl.soft_reset),
            .i_advance    (w_advance),
            .i_link       (w_link[k]),
            .o_link       (w_link[k+1])
        );
    end

    dtw_drain u_drain (
        .S_AXI_clk        (S_AXI_clk),
        .w_axi_rst        (w_axi_rst),
        .i_soft_reset     (w_ctrl.soft_reset),
        .i_link           (w_link[N_PE]),
        .i_sink_tready    (i_sink_tready),
        .o_sink_tvalid    (o_sink_tvalid),
        .o_sink_tdata     (o_sink_tdata),
        .o_advance        (w_advance),
        .o_result_pending (w_result_pending),
        .o_query_count    (w_query_count)
    );

endmodule

`default_nettype wire

// ==== hdl/dtw_csr.sv ====
/*
 * AXI4-Lite register slave for the DTW engine
 * Holds CONTROL, builds STATUS and answers the identity and count words
 */
`timescale 1ns/1ps
`default_nettype none

module dtw_csr (
    input  logic          S_AXI_clk,
    input  logic          w_axi_rst,

    input  logic          i_awvalid,
    input  logic [15:0]   i_awaddr,
    output logic          o_awready,
    input  logic          i_wvalid,
    input  logic [31:0]   i_wdata,
    output logic          o_wready,
    output logic          o_bvalid,
    input  logic          i_bready,
    output logic [1:0]    o_bresp,

    input  logic          i_arvalid,
    input  logic [15:0]   i_araddr,
    output logic          o_arready,
    output logic          o_rvalid,
    input  logic          i_rready,
    output logic [1:0]    o_rresp,
    output logic [31:0]   o_rdata,

    output csr_pkg::ctrl_t o_ctrl,
    input  logic          i_load_done,
    input  logic          i_result_pending,
    input  logic [31:0]   i_query_count
);
    import csr_pkg::*;

    ctrl_t    r_ctrl;
    status_t  w_status;
    reg_idx_t w_wr_idx;
    reg_idx_t w_rd_idx;
    logic     w_wr_accept;
    logic     w_rd_accept;
    logic     w_wr_known;
    logic     w_rd_known;
    logic [31:0] w_rd_data;

    // Address and data must arrive together
    assign w_wr_accept = i_awvalid && i_wvalid && !o_bvalid;
    assign w_rd_accept = i_arvalid && !o_rvalid;
    assign o_awready   = w_wr_accept;
    assign o_wready    = w_wr_accept;
    assign o_arready   = w_rd_accept;

    assign w_wr_idx = i_awaddr[15:2];
    assign w_rd_idx = i_araddr[15:2];
    assign o_ctrl   = r_ctrl;

    always_comb begin
        w_status = '0;
        w_status.load_done      = i_load_done;
        w_status.result_pending = i_result_pending;
    end

    // Read-only words still accept writes, which are ignored
    always_comb begin
        case (w_wr_idx)
            REG_CONTROL, REG_STATUS, REG_VERSION, REG_KEY, REG_QUERY_COUNT:
                w_wr_known = 1'b1;
            default:
                w_wr_known = 1'b0;
        endcase
    end

    always_comb begin
        w_rd_known = 1'b1;
        case (w_rd_idx)
            REG_CONTROL:     w_rd_data = r_ctrl;
            REG_STATUS:      w_rd_data = w_status;
            REG_VERSION:     w_rd_data = VERSION_WORD;
            REG_KEY:         w_rd_data = KEY_WORD;
            REG_QUERY_COUNT: w_rd_data = i_query_count;
            default: begin
                w_rd_data  = '0;
                w_rd_known = 1'b0;
            end
        endcase
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            r_ctrl   <= '0;
            o_bvalid <= 1'b0;
            o_rvalid <= 1'b0;
        end else begin
            if (w_wr_accept) begin
                o_bvalid <= 1'b1;
                if (w_wr_idx == REG_CONTROL) begin
                    r_ctrl <= ctrl_t'(i_wdata);
                end
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end

            if (w_rd_accept) begin
                o_rvalid <= 1'b1;
            end else if (i_rready) begin
                o_rvalid <= 1'b0;
            end
        end
    end

    // Response payload
    always_ff @(posedge S_AXI_clk) begin
        if (w_wr_accept) begin
            o_bresp <= w_wr_known ? RESP_OKAY : RESP_SLVERR;
        end
        if (w_rd_accept) begin
            o_rdata <= w_rd_data;
            o_rresp <= w_rd_known ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dtw_drain.sv ====
/*
 * Result drain
 * Holds finished scores for the sink stream and stalls the array
 * while a held score is refused
 */
`timescale 1ns/1ps
`default_nettype none

module dtw_drain (
    input  logic               S_AXI_clk,
    input  logic               w_axi_rst,
    input  logic               i_soft_reset,
    input  dtw_pkg::dtw_link_t i_link,
    input  logic               i_sink_tready,
    output logic               o_sink_tvalid,
    output dtw_pkg::score_t    o_sink_tdata,
    output logic               o_advance,
    output logic               o_result_pending,
    output logic [31:0]        o_query_count
);
    logic w_handover;
    logic w_capture;

    assign w_handover       = o_sink_tvalid && i_sink_tready;
    assign o_advance        = !o_sink_tvalid || i_sink_tready;
    assign o_result_pending = o_sink_tvalid;

    // Last row of a query carries D[M][N_PE] in left
    assign w_capture = o_advance && i_link.valid && !i_link.load && i_link.last;

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_soft_reset) begin
            o_sink_tvalid <= 1'b0;
            o_query_count <= '0;
        end else begin
            if (w_capture) begin
                o_sink_tvalid <= 1'b1;
            end else if (w_handover) begin
                o_sink_tvalid <= 1'b0;
            end
            if (w_handover) begin
                o_query_count <= o_query_count + 1'b1;
            end
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_capture) begin
            o_sink_tdata <= i_link.left;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dtw_feeder.sv ====
/*
 * Source stream feeder
 * Turns stream words into reference-load or query row items and
 * supplies the column-zero borders of each row
 */
`timescale 1ns/1ps
`default_nettype none

module dtw_feeder #(
    parameter int N_PE = 8
) (
    input  logic               S_AXI_clk,
    input  logic               w_axi_rst,
    input  csr_pkg::ctrl_t     i_ctrl,
    input  logic               i_advance,

    input  logic               i_src_tvalid,
    output logic               o_src_tready,
    input  logic [31:0]        i_src_tdata,
    input  logic               i_src_tlast,

    output dtw_pkg::dtw_link_t o_link,
    output logic               o_load_done
);
    import dtw_pkg::*;

    localparam int CNT_W = $clog2(N_PE + 1);

    dtw_link_t       r_link;
    logic [CNT_W-1:0] r_load_count;
    logic            r_first;
    logic            w_take;

    assign o_src_tready = i_ctrl.run && !i_ctrl.soft_reset && i_advance;
    assign w_take       = i_src_tvalid && o_src_tready;
    assign o_load_done  = (r_load_count == CNT_W'(N_PE));
    assign o_link       = r_link;

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_ctrl.soft_reset) begin
            r_link.valid <= 1'b0;
            r_load_count <= '0;
            r_first      <= 1'b1;
        end else if (i_advance) begin
            r_link.valid  <= w_take;
            r_link.load   <= !i_ctrl.mode;
            r_link.first  <= r_first && i_ctrl.mode;
            r_link.last   <= i_src_tlast;
            r_link.sample <= sample_t'(i_src_tdata[15:0]);
            // Column zero is infinite except D[0][0]
            r_link.left   <= SCORE_INF;
            r_link.diag   <= r_first ? '0 : SCORE_INF;

            if (w_take && !i_ctrl.mode && !o_load_done) begin
                r_load_count <= r_load_count + 1'b1;
            end
            // Next query starts after tlast
            if (w_take && i_ctrl.mode) begin
                r_first <= i_src_tlast;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dtw_pe.sv ====
/*
 * DTW processing element
 * Holds one reference sample and computes one column of the matrix
 */
`timescale 1ns/1ps
`default_nettype none

module dtw_pe (
    input  logic               S_AXI_clk,
    input  logic               w_axi_rst,
    input  logic               i_soft_reset,
    input  logic               i_advance,
    input  dtw_pkg::dtw_link_t i_link,
    output dtw_pkg::dtw_link_t o_link
);
    import dtw_pkg::*;

    sample_t          r_ref;
    score_t           r_col;
    dtw_link_t        r_out;
    logic signed [16:0] w_diff;
    logic [16:0]      w_mag;
    score_t           w_cost;
    score_t           w_up;
    score_t           w_min;
    logic [32:0]      w_sum;
    score_t           w_score;

    // Local cost |q - r|
    assign w_diff = 17'(i_link.sample) - 17'(r_ref);
    assign w_mag  = w_diff[16] ? 17'(-w_diff) : 17'(w_diff);
    assign w_cost = {15'b0, w_mag};

    // Row zero above the first query row is infinite
    assign w_up = i_link.first ? SCORE_INF : r_col;

    always_comb begin
        w_min = i_link.left;
        if (i_link.diag < w_min)
            w_min = i_link.diag;
        if (w_up < w_min)
            w_min = w_up;
    end

    assign w_sum   = {1'b0, w_min} + {1'b0, w_cost};
    assign w_score = w_sum[32] ? SCORE_INF : w_sum[31:0];
    assign o_link  = r_out;

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_soft_reset) begin
            r_out.valid <= 1'b0;
        end else if (i_advance) begin
            r_out.valid <= i_link.valid;
            r_out.load  <= i_link.load;
            r_out.first <= i_link.first;
            r_out.last  <= i_link.last;
            if (i_link.valid && i_link.load) begin
                // Shift the reference one element onward
                r_ref        <= i_link.sample;
                r_out.sample <= r_ref;
            end else if (i_link.valid) begin
                r_out.sample <= i_link.sample;
                r_out.left   <= w_score;
                r_out.diag   <= w_up;
                r_col        <= w_score;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dtw_pkg.sv ====
/*
 * DTW datapath types
 * Samples, saturating scores and the link word passed along the
 * systolic array of processing elements
 */
`default_nettype none

package dtw_pkg;

    localparam int SAMPLE_W = 16;
    localparam int SCORE_W  = 32;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [SCORE_W-1:0]         score_t;

    // Saturated score, stands in for an infinite border cell
    localparam score_t SCORE_INF = '1;

    // One item moving from an element to its right neighbour
    typedef struct packed {
        logic    valid;
        logic    load;
        logic    first;
        logic    last;
        sample_t sample;
        score_t  left;
        score_t  diag;
    } dtw_link_t;

endpackage

`default_nettype wire

// ==== testbench/dtw_accel_properties.sv ====
/*
 * Handshake assertions for the DTW engine
 * Bound to the top level, checks that offered responses and scores hold
 */
`timescale 1ns/1ps
`default_nettype none

module dtw_accel_properties (
    input logic        S_AXI_clk,
    input logic        w_axi_rst,
    input logic        i_bvalid,
    input logic        i_bready,
    input logic        i_rvalid,
    input logic        i_rready,
    input logic        i_sink_tvalid,
    input logic        i_sink_tready,
    input logic [31:0] i_sink_tdata
);

    a_bvalid_hold: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        i_bvalid && !i_bready |=> i_bvalid)
        else $error("Write response withdrawn before bready");

    a_rvalid_hold: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        i_rvalid && !i_rready |=> i_rvalid)
        else $error("Read data withdrawn before rready");

    // Score must stay put while the sink refuses it
    a_sink_hold: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        i_sink_tvalid && !i_sink_tready |=> i_sink_tvalid && $stable(i_sink_tdata))
        else $error("Sink score changed or dropped before tready");

endmodule

bind dtw_accel dtw_accel_properties u_properties (
    .S_AXI_clk     (S_AXI_clk),
    .w_axi_rst     (w_axi_rst),
    .i_bvalid      (o_bvalid),
    .i_bready      (i_bready),
    .i_rvalid      (o_rvalid),
    .i_rready      (i_rready),
    .i_sink_tvalid (o_sink_tvalid),
    .i_sink_tready (i_sink_tready),
    .i_sink_tdata  (o_sink_tdata)
);

`default_nettype wire

// ==== testbench/tb_dtw_accel.sv ====
/*
 * Testbench for the DTW distance engine
 * Drives AXI4-Lite and the source stream, checks sink scores
 * against a software DTW model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dtw_accel;
    import csr_pkg::*;

    localparam int N_PE      = 8;
    localparam int MAX_Q     = 12;
    localparam int N_QUERIES = 20;
    // Upper bound on source words over the whole run
    localparam int MAX_SAMPLES = 2 * N_PE + (2 * N_QUERIES + 1) * MAX_Q;
    localparam longint INF_SCORE = 64'h0000_0000_ffff_ffff;
    localparam logic [31:0] CTRL_LOAD  = 32'h0000_0002;
    localparam logic [31:0] CTRL_QUERY = 32'h0000_0006;

    logic        S_AXI_clk = 1'b0;
    logic        w_axi_rst;
    logic        i_awvalid, o_awready, i_wvalid, o_wready, o_bvalid, i_bready;
    logic        i_arvalid, o_arready, o_rvalid, i_rready;
    logic [15:0] i_awaddr, i_araddr;
    logic [31:0] i_wdata, o_rdata;
    logic [1:0]  o_bresp, o_rresp;
    logic        i_src_tvalid, o_src_tready, i_src_tlast;
    logic [31:0] i_src_tdata;
    logic        o_sink_tvalid, i_sink_tready, o_sink_tlast;
    logic [31:0] o_sink_tdata;
    logic [3:0]  o_sink_tdest, o_sink_tkeep;
    logic [7:0]  o_sink_tid;

    logic [31:0] exp_q [$];
    int          ref_s [N_PE];
    int          q_s [MAX_Q];
    int          errors;
    int          checks;
    int          n_results;
    logic        bp_on;
    string       test_name;

    dtw_accel #(.N_PE(N_PE)) dut (.*);

    always #5 S_AXI_clk = ~S_AXI_clk;

    // Full DTW matrix, row 0 and column 0 infinite except D[0][0]
    function automatic logic [31:0] dtw_ref(input int q [MAX_Q], input int qlen,
                                            input int r [N_PE]);
        longint d [0:MAX_Q][0:N_PE];
        longint best;
        longint cost;
        for (int i = 0; i <= MAX_Q; i++) begin
            for (int j = 0; j <= N_PE; j++) begin
                d[i][j] = INF_SCORE;
            end
        end
        d[0][0] = 0;
        for (int i = 1; i <= qlen; i++) begin
            for (int j = 1; j <= N_PE; j++) begin
                best = d[i-1][j];
                if (d[i][j-1] < best)
                    best = d[i][j-1];
                if (d[i-1][j-1] < best)
                    best = d[i-1][j-1];
                cost = (q[i-1] > r[j-1]) ? q[i-1] - r[j-1] : r[j-1] - q[i-1];
                d[i][j] = (best + cost > INF_SCORE) ? INF_SCORE : best + cost;
            end
        end
        return d[qlen][N_PE][31:0];
    endfunction

    task automatic compare_word(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error %s / %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic axi_write(input reg_idx_t idx, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge S_AXI_clk);
        i_awvalid = 1'b1;
        i_awaddr  = {idx, 2'b00};
        i_wvalid  = 1'b1;
        i_wdata   = data;
        @(posedge S_AXI_clk);
        compare_word("awready", 32'd1, o_awready);
        compare_word("wready", 32'd1, o_wready);
        @(negedge S_AXI_clk);
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        while (!o_bvalid) @(negedge S_AXI_clk);
        // Hold off the response for two cycles
        repeat (2) @(negedge S_AXI_clk);
        resp     = o_bresp;
        i_bready = 1'b1;
        @(negedge S_AXI_clk);
        i_bready = 1'b0;
    endtask

    task automatic axi_read(input reg_idx_t idx, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge S_AXI_clk);
        i_arvalid = 1'b1;
        i_araddr  = {idx, 2'b00};
        @(posedge S_AXI_clk);
        compare_word("arready", 32'd1, o_arready);
        @(negedge S_AXI_clk);
        i_arvalid = 1'b0;
        while (!o_rvalid) @(negedge S_AXI_clk);
        // Hold off the read data for two cycles
        repeat (2) @(negedge S_AXI_clk);
        data     = o_rdata;
        resp     = o_rresp;
        i_rready = 1'b1;
        @(negedge S_AXI_clk);
        i_rready = 1'b0;
    endtask

    task automatic send_word(input int value, input logic last);
        @(negedge S_AXI_clk);
        i_src_tvalid = 1'b1;
        i_src_tdata  = 32'(value);
        i_src_tlast  = last;
        @(posedge S_AXI_clk);
        while (!o_src_tready) @(posedge S_AXI_clk);
    endtask

    task automatic stream_idle();
        @(negedge S_AXI_clk);
        i_src_tvalid = 1'b0;
        i_src_tlast  = 1'b0;
    endtask

    task automatic send_random_query();
        int len;
        len = int'($urandom_range(MAX_Q, 1));
        for (int i = 0; i < len; i++) begin
            q_s[i] = int'($urandom_range(400)) - 200;
        end
        exp_q.push_back(dtw_ref(q_s, len, ref_s));
        for (int i = 0; i < len; i++) begin
            send_word(q_s[i], i == len - 1);
        end
    endtask

    // Reference goes in last sample first, so r_1 ends in element 0
    task automatic load_reference();
        logic [31:0] data;
        logic [1:0]  resp;
        status_t     st;
        for (int k = 0; k < N_PE; k++) begin
            ref_s[k] = int'($urandom_range(400)) - 200;
        end
        axi_write(REG_CONTROL, CTRL_LOAD, resp);
        for (int k = N_PE - 1; k >= 1; k--) begin
            send_word(ref_s[k], 1'b0);
        end
        stream_idle();
        axi_read(REG_STATUS, data, resp);
        st = status_t'(data);
        compare_word("load_done before last word", 32'd0, st.load_done);
        send_word(ref_s[0], 1'b0);
        stream_idle();
        axi_read(REG_STATUS, data, resp);
        st = status_t'(data);
        compare_word("load_done after last word", 32'd1, st.load_done);
        axi_write(REG_CONTROL, CTRL_QUERY, resp);
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) @(posedge S_AXI_clk);
    endtask

    always @(negedge S_AXI_clk) begin
        i_sink_tready <= bp_on ? ($urandom_range(3) != 0) : 1'b1;
    end

    // Scores leave in query order
    always @(posedge S_AXI_clk) begin
        if (!w_axi_rst && o_sink_tvalid && i_sink_tready) begin
            n_results++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Score %h arrived with no query outstanding", o_sink_tdata);
            end else begin
                compare_word("sink score", exp_q.pop_front(), o_sink_tdata);
            end
            compare_word("sink tlast", 32'd1, o_sink_tlast);
            compare_word("sink tdest", 32'd1, o_sink_tdest);
            compare_word("sink tid", 32'd0, o_sink_tid);
            compare_word("sink tkeep", 32'hf, o_sink_tkeep);
        end
    end

    initial begin
        repeat (20 * N_PE * MAX_SAMPLES + 2000) @(posedge S_AXI_clk);
        $display("Watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        void'($urandom(9));
        errors = 0;
        checks = 0;
        n_results = 0;
        bp_on = 1'b0;
        test_name = "reset";
        w_axi_rst = 1'b1;
        {i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready} = '0;
        i_awaddr = '0;
        i_araddr = '0;
        i_wdata = '0;
        {i_src_tvalid, i_src_tlast} = '0;
        i_src_tdata = '0;
        i_sink_tready = 1'b1;
        repeat (5) @(posedge S_AXI_clk);
        @(negedge S_AXI_clk);
        w_axi_rst = 1'b0;

        test_name = "identity";
        axi_read(REG_VERSION, data, resp);
        compare_word("VERSION", 32'h1000_0000, data);
        compare_word("VERSION resp", 2'b00, resp);
        axi_read(REG_KEY, data, resp);
        compare_word("KEY", 32'h0ca7_cafe, data);
        compare_word("KEY resp", 2'b00, resp);
        axi_read(14'd2, data, resp);
        compare_word("index 2 data", 32'd0, data);
        compare_word("index 2 resp", 2'b10, resp);
        axi_write(14'd7, 32'h1234_5678, resp);
        compare_word("index 7 write resp", 2'b10, resp);
        axi_read(REG_CONTROL, data, resp);
        compare_word("CONTROL after reset", 32'd0, data);
        axi_write(REG_CONTROL, 32'h0000_0004, resp);
        compare_word("CONTROL write resp", 2'b00, resp);
        axi_read(REG_CONTROL, data, resp);
        compare_word("CONTROL readback", 32'h0000_0004, data);
        axi_write(REG_CONTROL, 32'd0, resp);

        test_name = "reference_load";
        axi_read(REG_STATUS, data, resp);
        compare_word("load_done after reset", 32'd0, data[1]);
        load_reference();

        test_name = "distance";
        repeat (N_QUERIES) send_random_query();
        stream_idle();
        wait_results();

        test_name = "backpressure";
        @(posedge S_AXI_clk);
        bp_on = 1'b1;
        repeat (N_QUERIES) send_random_query();
        stream_idle();
        wait_results();
        bp_on = 1'b0;
        axi_read(REG_QUERY_COUNT, data, resp);
        compare_word("QUERY_COUNT", 2 * N_QUERIES, data);
        compare_word("scores received", 2 * N_QUERIES, n_results);

        test_name = "soft_reset";
        axi_write(REG_CONTROL, 32'h0000_0001, resp);
        axi_write(REG_CONTROL, 32'd0, resp);
        axi_read(REG_STATUS, data, resp);
        compare_word("load_done cleared", 32'd0, data[1]);
        axi_read(REG_QUERY_COUNT, data, resp);
        compare_word("QUERY_COUNT cleared", 32'd0, data);
        load_reference();
        send_random_query();
        stream_idle();
        wait_results();
        axi_read(REG_QUERY_COUNT, data, resp);
        compare_word("QUERY_COUNT after reload", 32'd1, data);

        repeat (4) @(posedge S_AXI_clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
